/* common/ib_pkg.sv */
// shared widths, debug command codes and debug instruction fields, imported by all buffer modules
`default_nettype none

package ib_pkg;

   // buffer geometry
   localparam int IB_DEPTH   = 4;                     // slots, fixed by the shift network
   localparam int INSTR_W    = 32;                    // instruction word
   localparam int PC_W       = 31;                    // halfword pc, bits 31 down to 1
   localparam int SLOT_W     = INSTR_W + PC_W + 2;    // word, pc, pc4 and icaf per slot
   localparam int DBG_ADDR_W = 12;                    // low debug address bits in use

   // debug command types
   localparam logic [1:0] DBG_TYPE_GPR = 2'd0;
   localparam logic [1:0] DBG_TYPE_CSR = 2'd1;
   localparam logic [1:0] DBG_TYPE_MEM = 2'd2;        // handled outside the buffer

   // fence csr only reachable from debug mode
   localparam logic [DBG_ADDR_W-1:0] CSR_DEBUG_FENCE = 12'h7c4;

   // fixed fields around the register or csr number
   // or x0, reg, x0 -> funct3 110, rd x0, op-reg
   localparam logic [14:0] OPC_GPR_READ_LO  = 15'b110_00000_0110011;
   // or reg, x0, x0 -> funct7, rs2, rs1 all zero, funct3 110
   localparam logic [19:0] OPC_GPR_WRITE_HI = 20'b0000000_00000_00000_110;
   localparam logic [6:0]  OPC_GPR_WRITE_LO = 7'b0110011;      // op-reg
   // csrrs x0, csr, x0
   localparam logic [19:0] OPC_CSR_READ_LO  = 20'b00000_010_00000_1110011;
   // csrrw x0, csr, x0 so the write data arrives on rs1
   localparam logic [19:0] OPC_CSR_WRITE_LO = 20'b00000_001_00000_1110011;

   // low debug address bits, read as a csr number or as a gpr index
   typedef union packed {
      logic [DBG_ADDR_W-1:0] csr;                     // whole field is the csr
      struct packed {
         logic [6:0] rsvd;                            // don't care for gpr access
         logic [4:0] idx;                             // x0 to x31
      } gpr;
   } dbg_addr_u;

endpackage

`default_nettype wire

/* ib/ib_ctl.sv */
// slot occupancy, flush register and write/shift selection of the instruction buffer, used by ib_top
`timescale 1ns/1ns
`default_nettype none

module ib_ctl
   import ib_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                flush,            // flush request, takes effect one cycle later
   input  logic                fetch_i0_valid,   // fetch offers i0
   input  logic                fetch_i1_valid,   // only together with i0
   input  logic                decode_i0,        // decode takes slot 0
   input  logic                decode_i1,        // decode takes slot 1 as well
   input  logic                debug_valid,      // synthesized debug instruction for slot 0
   output logic [IB_DEPTH-1:0] ib_valid,         // slot valids, always packed from slot 0
   output logic [IB_DEPTH-1:0] wr_i0,            // i0 lands in slot n
   output logic [IB_DEPTH-1:1] wr_i1,            // i1 lands in slot n
   output logic                shift_1_0,
   output logic                shift_2_1,
   output logic                shift_3_2,
   output logic                shift_2_0,
   output logic                shift_3_1,
   output logic [IB_DEPTH-1:0] slot_load         // per slot data enable
);

   logic                flush_q;                 // registered flush
   logic                i0_ok;                   // i0 accepted this cycle
   logic                i1_ok;
   logic                shift0;                  // nothing decoded
   logic                shift1;                  // one slot decoded
   logic                shift2;                  // two slots decoded
   logic [IB_DEPTH-1:0] shift_val;               // valids after removing decoded slots
   logic [IB_DEPTH-1:0] valid_d;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flush_q <= 1'b0;
      end else begin
         flush_q <= flush;
      end
   end

   // accept only with room, an offer without room is lost
   assign i0_ok = fetch_i0_valid & ~ib_valid[3] & ~flush_q;   // i0 needs slot 3 free
   assign i1_ok = fetch_i1_valid & ~ib_valid[2] & ~flush_q;   // i1 needs slot 2 free

   assign shift0 = ~decode_i0;
   assign shift1 =  decode_i0 & ~decode_i1;
   assign shift2 =  decode_i0 &  decode_i1;

   // occupancy as it stands once decode has taken its slots
   assign shift_val = ({IB_DEPTH{shift0}} & ib_valid) |
                      ({IB_DEPTH{shift1}} & {1'b0, ib_valid[3:1]}) |
                      ({IB_DEPTH{shift2}} & {2'b00, ib_valid[3:2]});

   // i0 goes to the first free slot after the shift
   assign wr_i0[0] = ~shift_val[0] & (i0_ok | debug_valid);   // debug only ever targets slot 0
   assign wr_i0[1] =  shift_val[0] & ~shift_val[1] & i0_ok;
   assign wr_i0[2] =  shift_val[1] & ~shift_val[2] & i0_ok;
   assign wr_i0[3] =  shift_val[2] & ~shift_val[3] & i0_ok;

   // i1 one slot above i0
   assign wr_i1[1] = ~shift_val[0] & i1_ok;
   assign wr_i1[2] =  shift_val[0] & ~shift_val[1] & i1_ok;
   assign wr_i1[3] =  shift_val[1] & ~shift_val[2] & i1_ok;

   // move surviving entries down
   assign shift_1_0 = shift1 & ib_valid[1];
   assign shift_2_1 = shift1 & ib_valid[2];
   assign shift_3_2 = shift1 & ib_valid[3];
   assign shift_2_0 = shift2 & ib_valid[2];
   assign shift_3_1 = shift2 & ib_valid[3];

   assign slot_load = wr_i0 |
                      {wr_i1, 1'b0} |
                      {1'b0, shift_3_2, shift_2_1 | shift_3_1, shift_1_0 | shift_2_0};

   // new valids, dropped as a whole by the registered flush
   assign valid_d = (shift_val | wr_i0 | {wr_i1, 1'b0}) & ~{IB_DEPTH{flush_q}};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ib_valid <= '0;
      end else begin
         ib_valid <= valid_d;
      end
   end

endmodule

`default_nettype wire

/* ib/ib_slots.sv */
// four instruction data slots with fetch write and shift-down multiplexing, used by ib_top
`timescale 1ns/1ns
`default_nettype none

module ib_slots
   import ib_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic [INSTR_W-1:0]  fetch_i0_instr,
   input  logic [PC_W-1:0]     fetch_i0_pc,      // pc bits 31 down to 1
   input  logic                fetch_i0_pc4,     // 4-byte instruction, else 2-byte
   input  logic                fetch_i0_icaf,    // access fault on fetch
   input  logic [INSTR_W-1:0]  fetch_i1_instr,
   input  logic [PC_W-1:0]     fetch_i1_pc,
   input  logic                fetch_i1_pc4,
   input  logic                fetch_i1_icaf,

   input  logic                debug_valid,      // slot 0 takes debug_instr instead of i0
   input  logic [INSTR_W-1:0]  debug_instr,

   input  logic [IB_DEPTH-1:0] wr_i0,
   input  logic [IB_DEPTH-1:1] wr_i1,
   input  logic                shift_1_0,
   input  logic                shift_2_1,
   input  logic                shift_3_2,
   input  logic                shift_2_0,
   input  logic                shift_3_1,
   input  logic [IB_DEPTH-1:0] slot_load,

   output logic [INSTR_W-1:0]  dec_i0_instr,     // slot 0 to decode
   output logic [PC_W-1:0]     dec_i0_pc,
   output logic                dec_i0_pc4,
   output logic                dec_i0_icaf,
   output logic [INSTR_W-1:0]  dec_i1_instr,     // slot 1 to decode
   output logic [PC_W-1:0]     dec_i1_pc,
   output logic                dec_i1_pc4,
   output logic                dec_i1_icaf
);

   logic [IB_DEPTH-1:0][SLOT_W-1:0] slot_q;      // {instr, pc, pc4, icaf} per slot
   logic [IB_DEPTH-1:0][SLOT_W-1:0] slot_d;
   logic [SLOT_W-1:0]               i0_data;
   logic [SLOT_W-1:0]               i1_data;
   logic [SLOT_W-1:0]               i0_slot0;    // i0 or debug word for slot 0
   logic [INSTR_W-1:0]              slot0_instr;

   assign i0_data = {fetch_i0_instr, fetch_i0_pc, fetch_i0_pc4, fetch_i0_icaf};
   assign i1_data = {fetch_i1_instr, fetch_i1_pc, fetch_i1_pc4, fetch_i1_icaf};

   // debug replaces only the word, side fields still follow lane i0
   assign slot0_instr = debug_valid ? debug_instr : fetch_i0_instr;
   assign i0_slot0    = {slot0_instr, fetch_i0_pc, fetch_i0_pc4, fetch_i0_icaf};

   // top slot is only ever written from fetch
   assign slot_d[3] = ({SLOT_W{wr_i0[3]}} & i0_data) |
                      ({SLOT_W{wr_i1[3]}} & i1_data);

   assign slot_d[2] = ({SLOT_W{wr_i0[2]}} & i0_data) |
                      ({SLOT_W{wr_i1[2]}} & i1_data) |
                      ({SLOT_W{shift_3_2}} & slot_q[3]);

   assign slot_d[1] = ({SLOT_W{wr_i0[1]}} & i0_data) |
                      ({SLOT_W{wr_i1[1]}} & i1_data) |
                      ({SLOT_W{shift_2_1}} & slot_q[2]) |
                      ({SLOT_W{shift_3_1}} & slot_q[3]);  // double shift

   // i1 can never land in slot 0
   assign slot_d[0] = ({SLOT_W{wr_i0[0]}} & i0_slot0) |
                      ({SLOT_W{shift_1_0}} & slot_q[1]) |
                      ({SLOT_W{shift_2_0}} & slot_q[2]);  // double shift

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_q <= '0;
      end else begin
         for (int i = 0; i < IB_DEPTH; i++) begin
            if (slot_load[i]) begin
               slot_q[i] <= slot_d[i];                   // hold when not selected
            end
         end
      end
   end

   // two oldest slots face decode
   assign {dec_i0_instr, dec_i0_pc, dec_i0_pc4, dec_i0_icaf} = slot_q[0];
   assign {dec_i1_instr, dec_i1_pc, dec_i1_pc4, dec_i1_icaf} = slot_q[1];

endmodule

`default_nettype wire

/* debug/dbg_inject.sv */
// turns a debugger gpr/csr access into an instruction for slot 0 and raises the debug flags
`timescale 1ns/1ns
`default_nettype none

module dbg_inject
   import ib_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  dbg_cmd_valid,   // command present this cycle
   input  logic                  dbg_cmd_write,   // write, else read
   input  logic [1:0]            dbg_cmd_type,    // gpr, csr or memory
   input  logic [DBG_ADDR_W-1:0] dbg_cmd_addr,    // csr number or gpr index
   output logic                  debug_valid,     // command goes into the buffer
   output logic [INSTR_W-1:0]    debug_instr,     // synthesized word
   output logic                  dbg_wdata_rs1,   // write data rides on rs1 next cycle
   output logic                  dbg_fence        // debug fence next cycle
);

   dbg_addr_u daddr;
   logic      dbg_rd;
   logic      dbg_wr;
   logic      rd_gpr;
   logic      wr_gpr;
   logic      rd_csr;
   logic      wr_csr;
   logic      fence_d;

   assign daddr = dbg_cmd_addr;

   // memory accesses bypass the buffer
   assign debug_valid = dbg_cmd_valid & (dbg_cmd_type != DBG_TYPE_MEM);

   assign dbg_rd = debug_valid & ~dbg_cmd_write;
   assign dbg_wr = debug_valid &  dbg_cmd_write;

   assign rd_gpr = dbg_rd & (dbg_cmd_type == DBG_TYPE_GPR);
   assign wr_gpr = dbg_wr & (dbg_cmd_type == DBG_TYPE_GPR);
   assign rd_csr = dbg_rd & (dbg_cmd_type == DBG_TYPE_CSR);
   assign wr_csr = dbg_wr & (dbg_cmd_type == DBG_TYPE_CSR);

   // one-hot and-or select of the four encodings
   assign debug_instr =
      ({INSTR_W{rd_gpr}} & {12'b0, daddr.gpr.idx, OPC_GPR_READ_LO}) |         // reg on rs1
      ({INSTR_W{wr_gpr}} & {OPC_GPR_WRITE_HI, daddr.gpr.idx, OPC_GPR_WRITE_LO}) | // reg on rd
      ({INSTR_W{rd_csr}} & {daddr.csr, OPC_CSR_READ_LO}) |
      ({INSTR_W{wr_csr}} & {daddr.csr, OPC_CSR_WRITE_LO});

   // core is halted and the buffer empty, so the word decodes the very next cycle
   assign fence_d = wr_csr & (daddr.csr == CSR_DEBUG_FENCE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dbg_wdata_rs1 <= 1'b0;
         dbg_fence     <= 1'b0;
      end else begin
         dbg_wdata_rs1 <= wr_gpr | wr_csr;   // any register write
         dbg_fence     <= fence_d;
      end
   end

endmodule

`default_nettype wire

/* rtl/ib_top.sv */
// top of the dual-issue instruction buffer, connects control, debug injection and data slots
`timescale 1ns/1ns
`default_nettype none

module ib_top
   import ib_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,

   // fetch lanes
   input  logic                  fetch_i0_valid,
   input  logic [INSTR_W-1:0]    fetch_i0_instr,
   input  logic [PC_W-1:0]       fetch_i0_pc,
   input  logic                  fetch_i0_pc4,
   input  logic                  fetch_i0_icaf,
   input  logic                  fetch_i1_valid,   // only with i0
   input  logic [INSTR_W-1:0]    fetch_i1_instr,
   input  logic [PC_W-1:0]       fetch_i1_pc,
   input  logic                  fetch_i1_pc4,
   input  logic                  fetch_i1_icaf,

   input  logic                  flush,

   // decode handshake
   input  logic                  decode_i0,
   input  logic                  decode_i1,

   // debugger command, only with the buffer empty
   input  logic                  dbg_cmd_valid,
   input  logic                  dbg_cmd_write,
   input  logic [1:0]            dbg_cmd_type,
   input  logic [DBG_ADDR_W-1:0] dbg_cmd_addr,

   output logic [IB_DEPTH-1:0]   ib_valid,
   output logic [INSTR_W-1:0]    dec_i0_instr,
   output logic [PC_W-1:0]       dec_i0_pc,
   output logic                  dec_i0_pc4,
   output logic                  dec_i0_icaf,
   output logic [INSTR_W-1:0]    dec_i1_instr,
   output logic [PC_W-1:0]       dec_i1_pc,
   output logic                  dec_i1_pc4,
   output logic                  dec_i1_icaf,
   output logic                  dbg_wdata_rs1,
   output logic                  dbg_fence
);

   logic                debug_valid;
   logic [INSTR_W-1:0]  debug_instr;
   logic [IB_DEPTH-1:0] wr_i0;
   logic [IB_DEPTH-1:1] wr_i1;
   logic                shift_1_0;
   logic                shift_2_1;
   logic                shift_3_2;
   logic                shift_2_0;
   logic                shift_3_1;
   logic [IB_DEPTH-1:0] slot_load;

   ib_ctl u_ctl (
      .clk            (clk),
      .rst_n          (rst_n),
      .flush          (flush),
      .fetch_i0_valid (fetch_i0_valid),
      .fetch_i1_valid (fetch_i1_valid),
      .decode_i0      (decode_i0),
      .decode_i1      (decode_i1),
      .debug_valid    (debug_valid),
      .ib_valid       (ib_valid),
      .wr_i0          (wr_i0),
      .wr_i1          (wr_i1),
      .shift_1_0      (shift_1_0),
      .shift_2_1      (shift_2_1),
      .shift_3_2      (shift_3_2),
      .shift_2_0      (shift_2_0),
      .shift_3_1      (shift_3_1),
      .slot_load      (slot_load)
   );

   dbg_inject u_dbg (
      .clk           (clk),
      .rst_n         (rst_n),
      .dbg_cmd_valid (dbg_cmd_valid),
      .dbg_cmd_write (dbg_cmd_write),
      .dbg_cmd_type  (dbg_cmd_type),
      .dbg_cmd_addr  (dbg_cmd_addr),
      .debug_valid   (debug_valid),
      .debug_instr   (debug_instr),
      .dbg_wdata_rs1 (dbg_wdata_rs1),
      .dbg_fence     (dbg_fence)
   );

   ib_slots u_slots (
      .clk            (clk),
      .rst_n          (rst_n),
      .fetch_i0_instr (fetch_i0_instr),
      .fetch_i0_pc    (fetch_i0_pc),
      .fetch_i0_pc4   (fetch_i0_pc4),
      .fetch_i0_icaf  (fetch_i0_icaf),
      .fetch_i1_instr (fetch_i1_instr),
      .fetch_i1_pc    (fetch_i1_pc),
      .fetch_i1_pc4   (fetch_i1_pc4),
      .fetch_i1_icaf  (fetch_i1_icaf),
      .debug_valid    (debug_valid),
      .debug_instr    (debug_instr),
      .wr_i0          (wr_i0),
      .wr_i1          (wr_i1),
      .shift_1_0      (shift_1_0),
      .shift_2_1      (shift_2_1),
      .shift_3_2      (shift_3_2),
      .shift_2_0      (shift_2_0),
      .shift_3_1      (shift_3_1),
      .slot_load      (slot_load),
      .dec_i0_instr   (dec_i0_instr),
      .dec_i0_pc      (dec_i0_pc),
      .dec_i0_pc4     (dec_i0_pc4),
      .dec_i0_icaf    (dec_i0_icaf),
      .dec_i1_instr   (dec_i1_instr),
      .dec_i1_pc      (dec_i1_pc),
      .dec_i1_pc4     (dec_i1_pc4),
      .dec_i1_icaf    (dec_i1_icaf)
   );

endmodule

`default_nettype wire

/* bench/ib_props.sv */
// concurrent checks on the buffer control, bound into every ib_ctl instance
`timescale 1ns/1ns
`default_nettype none

module ib_props
   import ib_pkg::*;
(
   input logic                clk,
   input logic                rst_n,
   input logic                flush_q,
   input logic [IB_DEPTH-1:0] ib_valid,
   input logic [IB_DEPTH-1:0] wr_i0,
   input logic [IB_DEPTH-1:1] wr_i1
);

   // occupancy fills upward from slot 0 with no holes
   valid_packed: assert property (@(posedge clk) disable iff (!rst_n)
      ib_valid inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
      else $error("slot valids not contiguous from slot 0: %b", ib_valid);

   i1_needs_i0: assert property (@(posedge clk) disable iff (!rst_n)
      (|wr_i1) |-> (|wr_i0))
      else $error("i1 written without i0");

   flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
      flush_q |=> (ib_valid == '0))
      else $error("valids still set one cycle after registered flush");

endmodule

bind ib_ctl ib_props u_props (
   .clk      (clk),
   .rst_n    (rst_n),
   .flush_q  (flush_q),
   .ib_valid (ib_valid),
   .wr_i0    (wr_i0),
   .wr_i1    (wr_i1)
);

`default_nettype wire

/* bench/ib_tb.sv */
// testbench for ib_top, runs flow, overflow, flush and debug tests against a queue model
`timescale 1ns/1ns
`default_nettype none

module ib_tb
   import ib_pkg::*;
();

   localparam int CLK_PERIOD  = 100;
   localparam int FLOW_CYCLES = 1500;
   localparam int OVF_CYCLES  = 12;
   localparam int ENC_CMDS    = 10;
   localparam int FLAG_CMDS   = 40;
   localparam int DRAIN_MAX   = 4;
   // reset, flow, overflow, flush, three cycles per command, one drain per test
   localparam int TEST_CYCLES = 3 + FLOW_CYCLES + OVF_CYCLES + 5 +
                                (ENC_CMDS + FLAG_CMDS) * 3 + 5 * DRAIN_MAX;

   typedef struct packed {
      logic [INSTR_W-1:0] instr;
      logic [PC_W-1:0]    pc;
      logic               pc4;
      logic               icaf;
   } entry_t;

   logic                  clk, rst_n, flush, decode_i0, decode_i1;
   logic                  fetch_i0_valid, fetch_i0_pc4, fetch_i0_icaf;
   logic                  fetch_i1_valid, fetch_i1_pc4, fetch_i1_icaf;
   logic [INSTR_W-1:0]    fetch_i0_instr, fetch_i1_instr, dec_i0_instr, dec_i1_instr;
   logic [PC_W-1:0]       fetch_i0_pc, fetch_i1_pc, dec_i0_pc, dec_i1_pc;
   logic                  dec_i0_pc4, dec_i0_icaf, dec_i1_pc4, dec_i1_icaf;
   logic                  dbg_cmd_valid, dbg_cmd_write, dbg_wdata_rs1, dbg_fence;
   logic [1:0]            dbg_cmd_type;
   logic [DBG_ADDR_W-1:0] dbg_cmd_addr;
   logic [IB_DEPTH-1:0]   ib_valid;

   entry_t              mq[$];                     // model queue, oldest first
   logic                m_flush_q = 1'b0;
   logic                m_wdata   = 1'b0;
   logic                m_fence   = 1'b0;
   logic [IB_DEPTH-1:0] want_valid;                // pattern forced by the flush/overflow rules
   logic                want_on   = 1'b0;
   logic                checking  = 1'b0;
   int                  seed      = 28;
   int                  errors    = 0;
   int                  checks    = 0;
   int                  tests_run = 0;
   int                  tests_failed = 0;
   int                  test_err0 = 0;
   string               test_name = "reset";

   ib_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #((TEST_CYCLES + 50) * CLK_PERIOD);
      $display("watchdog expired in test %s, run did not finish in time", test_name);
      $display("ERRORS FOUND");
      $finish;
   end

   // risc-v words built field by field: funct7/csr, rs2, rs1, funct3, rd, opcode
   function automatic logic [INSTR_W-1:0] ref_debug_instr(input logic write,
         input logic [1:0] ctype, input logic [DBG_ADDR_W-1:0] addr);
      dbg_addr_u a;
      logic [INSTR_W-1:0] w;
      a = addr;
      w = '0;
      if (ctype == DBG_TYPE_GPR && write) begin
         w = {7'd0, 5'd0, 5'd0, 3'b110, a.gpr.idx, 7'b0110011};   // or reg, x0, x0
      end else if (ctype == DBG_TYPE_GPR) begin
         w = {7'd0, 5'd0, a.gpr.idx, 3'b110, 5'd0, 7'b0110011};   // or x0, reg, x0
      end else if (ctype == DBG_TYPE_CSR) begin
         w = {a.csr, 5'd0, (write ? 3'b001 : 3'b010), 5'd0, 7'b1110011};  // csrrw / csrrs
      end
      return w;
   endfunction

   function automatic int rand_below(input int lim);
      return $unsigned($random(seed)) % lim;
   endfunction

   task automatic check_word(input string what, input logic [INSTR_W-1:0] exp,
                             input logic [INSTR_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_pc(input string what, input logic [PC_W-1:0] exp,
                           input logic [PC_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   // one rising edge of the model, inputs as the dut sees them
   task automatic model_edge();
      int   n;
      logic dbg_in;
      n      = mq.size();                                  // room judged before decode
      dbg_in = dbg_cmd_valid && dbg_cmd_type != DBG_TYPE_MEM;
      if (decode_i0 && mq.size() > 0) void'(mq.pop_front());
      if (decode_i1 && mq.size() > 0) void'(mq.pop_front());
      if (dbg_in) begin
         mq.push_back('{ref_debug_instr(dbg_cmd_write, dbg_cmd_type, dbg_cmd_addr),
                        fetch_i0_pc, fetch_i0_pc4, fetch_i0_icaf});  // side fields from i0
      end else if (fetch_i0_valid && n < IB_DEPTH) begin
         mq.push_back('{fetch_i0_instr, fetch_i0_pc, fetch_i0_pc4, fetch_i0_icaf});
      end
      if (fetch_i1_valid && n < IB_DEPTH - 1) begin
         mq.push_back('{fetch_i1_instr, fetch_i1_pc, fetch_i1_pc4, fetch_i1_icaf});
      end
      if (m_flush_q) mq.delete();                          // offers refused, slots dropped
      m_wdata   = dbg_in && dbg_cmd_write && dbg_cmd_type inside {DBG_TYPE_GPR, DBG_TYPE_CSR};
      m_fence   = dbg_in && dbg_cmd_write && dbg_cmd_type == DBG_TYPE_CSR &&
                  dbg_cmd_addr == CSR_DEBUG_FENCE;
      m_flush_q = flush;
   endtask

   task automatic step();
      @(posedge clk);
      model_edge();
   endtask

   task automatic idle_inputs();
      {fetch_i0_valid, fetch_i1_valid, decode_i0, decode_i1, flush} <= '0;
      {fetch_i0_instr, fetch_i0_pc, fetch_i0_pc4, fetch_i0_icaf} <= '0;
      {fetch_i1_instr, fetch_i1_pc, fetch_i1_pc4, fetch_i1_icaf} <= '0;
      {dbg_cmd_valid, dbg_cmd_write, dbg_cmd_type, dbg_cmd_addr} <= '0;
   endtask

   task automatic drive_fetch(input logic v0, input logic v1);
      fetch_i0_valid <= v0;
      fetch_i0_instr <= $random(seed);
      fetch_i0_pc    <= PC_W'($random(seed));
      {fetch_i0_pc4, fetch_i0_icaf} <= 2'($random(seed));
      fetch_i1_valid <= v1;
      fetch_i1_instr <= $random(seed);
      fetch_i1_pc    <= PC_W'($random(seed));
      {fetch_i1_pc4, fetch_i1_icaf} <= 2'($random(seed));
   endtask

   task automatic drive_decode(input int n);
      decode_i0 <= (n > 0);
      decode_i1 <= (n > 1);
   endtask

   task automatic expect_valid(input logic [IB_DEPTH-1:0] v);
      want_valid = v;
      want_on    = 1'b1;
   endtask

   // decode until empty, bounded
   task automatic drain();
      int k;
      k = 0;
      idle_inputs();
      while (mq.size() > 0 && k < DRAIN_MAX) begin
         drive_decode(mq.size() > 1 ? 2 : 1);
         step();
         k++;
      end
      idle_inputs();
      if (mq.size() != 0) begin
         errors++;
         $display("buffer did not drain within %0d cycles in test %s", DRAIN_MAX, test_name);
      end
   endtask

   // command, hold so slot 0 is seen, then decode it
   task automatic issue_cmd(input logic write, input logic [1:0] ctype,
                            input logic [DBG_ADDR_W-1:0] addr);
      drive_fetch(1'b0, 1'b0);
      {dbg_cmd_valid, dbg_cmd_write, dbg_cmd_type, dbg_cmd_addr} <= {1'b1, write, ctype, addr};
      step();
      idle_inputs();
      step();
      drive_decode(mq.size() > 0 ? 1 : 0);
      step();
      idle_inputs();
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      drain();
      tests_run++;
      if (errors == test_err0) begin
         $display("test %s ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s had %0d errors", test_name, errors - test_err0);
      end
   endtask

   // compare process, outputs are stable at the falling edge
   always @(negedge clk) begin
      if (checking) begin
         for (int i = 0; i < IB_DEPTH; i++) begin
            check_bit($sformatf("ib_valid[%0d]", i), i < mq.size(), ib_valid[i]);
            if (want_on) check_bit($sformatf("rule ib_valid[%0d]", i), want_valid[i], ib_valid[i]);
         end
         want_on = 1'b0;
         if (mq.size() > 0) begin
            check_word("dec_i0_instr", mq[0].instr, dec_i0_instr);
            check_pc("dec_i0_pc", mq[0].pc, dec_i0_pc);
            check_bit("dec_i0_pc4", mq[0].pc4, dec_i0_pc4);
            check_bit("dec_i0_icaf", mq[0].icaf, dec_i0_icaf);
         end
         if (mq.size() > 1) begin
            check_word("dec_i1_instr", mq[1].instr, dec_i1_instr);
            check_pc("dec_i1_pc", mq[1].pc, dec_i1_pc);
            check_bit("dec_i1_pc4", mq[1].pc4, dec_i1_pc4);
            check_bit("dec_i1_icaf", mq[1].icaf, dec_i1_icaf);
         end
         check_bit("dbg_wdata_rs1", m_wdata, dbg_wdata_rs1);
         check_bit("dbg_fence", m_fence, dbg_fence);
      end
   end

   initial begin
      int n;
      int ndec;
      logic v0;
      rst_n <= 1'b0;
      idle_inputs();
      repeat (3) @(posedge clk);
      rst_n    <= 1'b1;
      checking = 1'b1;

      begin_test("ordered_flow");
      for (int c = 0; c < FLOW_CYCLES; c++) begin
         n    = mq.size();
         ndec = rand_below(3);
         v0   = (n < IB_DEPTH) && rand_below(4) != 0;        // offers stay within room
         drive_decode(ndec > n ? n : ndec);
         drive_fetch(v0, v0 && n < IB_DEPTH - 1 && rand_below(2) != 0);
         step();
      end
      end_test();

      begin_test("overflow");
      for (int c = 0; c < OVF_CYCLES; c++) begin
         drive_fetch(1'b1, c != 0);                        // fills 1, 3, then 4, rest dropped
         step();
      end
      expect_valid({IB_DEPTH{1'b1}});
      end_test();

      begin_test("flush");
      drive_fetch(1'b1, 1'b1);
      step();
      drive_fetch(1'b1, 1'b0);
      flush <= 1'b1;
      step();                                              // flush registered, i0 still taken
      flush <= 1'b0;
      drive_fetch(1'b1, 1'b1);                             // refused offer
      step();
      expect_valid('0);
      idle_inputs();
      step();
      expect_valid('0);
      step();
      end_test();

      begin_test("debug_encodings");
      issue_cmd(1'b0, DBG_TYPE_GPR, 12'h005);
      issue_cmd(1'b0, DBG_TYPE_GPR, 12'hfe1);              // upper bits ignored for gpr
      issue_cmd(1'b1, DBG_TYPE_GPR, 12'h011);
      issue_cmd(1'b1, DBG_TYPE_GPR, 12'hc3f);
      issue_cmd(1'b0, DBG_TYPE_CSR, 12'h300);
      issue_cmd(1'b0, DBG_TYPE_CSR, CSR_DEBUG_FENCE);
      issue_cmd(1'b1, DBG_TYPE_CSR, 12'h341);
      issue_cmd(1'b1, DBG_TYPE_CSR, CSR_DEBUG_FENCE);
      issue_cmd(1'b0, DBG_TYPE_MEM, 12'h010);
      issue_cmd(1'b1, DBG_TYPE_MEM, 12'h7c4);              // memory type never enters
      end_test();

      begin_test("debug_flags");
      for (int c = 0; c < FLAG_CMDS; c++) begin
         issue_cmd(rand_below(2) != 0, 2'(rand_below(3)),
                   rand_below(4) == 0 ? CSR_DEBUG_FENCE : DBG_ADDR_W'($random(seed)));
      end
      end_test();

      @(negedge clk);
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
common/ib_pkg.sv
ib/ib_ctl.sv
ib/ib_slots.sv
debug/dbg_inject.sv
rtl/ib_top.sv
bench/ib_props.sv
bench/ib_tb.sv

/* Bender.yml */
package:
  name: ib_buffer

sources:
  # package first, then blocks, then the top level
  - common/ib_pkg.sv
  - ib/ib_ctl.sv
  - ib/ib_slots.sv
  - debug/dbg_inject.sv
  - rtl/ib_top.sv
  - target: test
    files:
      - bench/ib_props.sv
      - bench/ib_tb.sv
